// File: Makefile
# verilator build and run of the uart link testbench
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module uart_link_tb -f uart_link.f
	./obj_dir/Vuart_link_tb | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/uart_controller.sv
// ====================
// uart command controller
// decodes host commands for the core, sequences outbound frames
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_controller import uart_link_pkg::*; (
  input  logic     i_CLK,
  input  logic     i_RST,
  // outbound frames from the core
  input  frame_t   i_UART_DATA_TX,
  input  logic     i_UART_DATA_TX_VALID,
  output logic     o_UART_DATA_TX_READY,
  // inbound command words to the core
  output rx_word_t o_UART_DATA_RX,
  output logic     o_UART_DATA_RX_VALID,  // one-cycle strobe
  input  logic     i_CORE_BUSY,
  // receiver side
  input  logic     i_RX_VALID,
  input  byte_t    i_RX_BYTE,
  // transmitter side
  output logic     o_TX_START,
  output byte_t    o_TX_BYTE,
  input  logic     i_TX_DONE
);

  ctrl_state_t r_state;
  logic        r_tx_ready;   // idle and free for a frame
  logic [2:0]  r_byte_cnt;   // bytes left to send
  frame_t      r_frame;      // shifts left one byte per character
  logic        w_is_read;
  logic        w_accept_word;
  logic        w_accept_read;
  logic        w_take_frame;
  logic        w_byte_sent;

  // ==================== decode
  assign w_is_read = (i_RX_BYTE == CMD_ADS_READ_REG) ||
                     (i_RX_BYTE == CMD_MPR_READ_REG);

  // busy core takes stop only, idle core takes run and reg reads
  assign w_accept_word = i_CORE_BUSY ? (i_RX_BYTE == CMD_STOP) :
                                       (i_RX_BYTE == CMD_RUN);
  assign w_accept_read = !i_CORE_BUSY && w_is_read;

  // rx byte wins over a frame in the same cycle
  assign o_UART_DATA_TX_READY = r_tx_ready && !i_RX_VALID;

  assign w_take_frame = (r_state == ST_IDLE) && i_UART_DATA_TX_VALID &&
                        o_UART_DATA_TX_READY;
  assign w_byte_sent  = (r_state == ST_TX_WAIT) && i_TX_DONE;

  // ==================== fsm
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state              <= ST_IDLE;
      r_tx_ready           <= 1'b0;
      r_byte_cnt           <= '0;
      o_UART_DATA_RX       <= '0;
      o_UART_DATA_RX_VALID <= 1'b0;
      o_TX_START           <= 1'b0;
    end else begin
      o_UART_DATA_RX_VALID <= 1'b0;  // strobes default low
      o_TX_START           <= 1'b0;
      case (r_state)
        ST_IDLE: begin
          r_tx_ready <= 1'b1;
          if (i_RX_VALID) begin
            if (w_accept_word) begin
              o_UART_DATA_RX[15:8] <= i_RX_BYTE;  // low byte kept
              o_UART_DATA_RX_VALID <= 1'b1;
            end else if (w_accept_read) begin
              o_UART_DATA_RX[15:8] <= i_RX_BYTE;  // hold cmd until address
              r_tx_ready           <= 1'b0;
              r_state              <= ST_RX_ADDR;
            end
            // anything else dropped
          end else if (w_take_frame) begin
            r_tx_ready <= 1'b0;
            r_state    <= ST_TX_DECODE;
          end
        end

        ST_RX_ADDR: begin
          if (i_RX_VALID) begin
            o_UART_DATA_RX[7:0]  <= i_RX_BYTE;
            o_UART_DATA_RX_VALID <= 1'b1;
            r_state              <= ST_IDLE;
          end
        end

        ST_TX_DECODE: begin
          case (r_frame[55:48])
            HDR_ADS_DATA: begin
              r_byte_cnt <= FRAME_BYTES_LONG;
              r_state    <= ST_TX_LOAD;
            end
            CMD_ADS_READ_REG, CMD_MPR_READ_REG: begin
              r_byte_cnt <= FRAME_BYTES_SHORT;  // reg echo
              r_state    <= ST_TX_LOAD;
            end
            default: r_state <= ST_IDLE;  // unknown header, drop frame
          endcase
        end

        ST_TX_LOAD: begin
          o_TX_START <= 1'b1;  // byte register loads in same cycle
          r_byte_cnt <= r_byte_cnt - 3'd1;
          r_state    <= ST_TX_WAIT;
        end

        ST_TX_WAIT: begin
          if (i_TX_DONE) begin
            r_state <= (r_byte_cnt == 3'd0) ? ST_IDLE : ST_TX_LOAD;
          end
        end

        default: r_state <= ST_IDLE;
      endcase
    end
  end

  // ==================== frame data
  always_ff @(posedge i_CLK) begin
    if (w_take_frame) begin
      r_frame <= i_UART_DATA_TX;
    end else if (w_byte_sent) begin
      r_frame <= {r_frame[47:0], 8'h00};  // next byte to the top
    end
    if (r_state == ST_TX_LOAD) begin
      o_TX_BYTE <= r_frame[55:48];  // header first
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_link_pkg.sv
// ====================
// uart link shared types, command codes and controller states
// ====================
`default_nettype none

package uart_link_pkg;

  // ==================== types
  typedef logic [7:0]  byte_t;     // one serial character
  typedef logic [55:0] frame_t;    // outbound frame, header in top byte
  typedef logic [15:0] rx_word_t;  // {command, address} to the core

  // ==================== command codes
  // host to core
  localparam byte_t CMD_RUN          = 8'h52;  // 'R'
  localparam byte_t CMD_STOP         = 8'h53;  // 'S'
  localparam byte_t CMD_ADS_READ_REG = 8'h61;  // 'a', followed by address byte
  localparam byte_t CMD_MPR_READ_REG = 8'h6D;  // 'm', followed by address byte

  // core to host frame headers
  localparam byte_t HDR_ADS_DATA     = 8'hAA;  // full sensor data frame
  localparam byte_t HDR_MPR_DATA     = 8'hBB;  // reserved, never transmitted

  // bytes per outbound frame kind
  localparam logic [2:0] FRAME_BYTES_LONG  = 3'd7;  // sensor data
  localparam logic [2:0] FRAME_BYTES_SHORT = 3'd3;  // register read echo

  // ==================== controller fsm
  typedef enum logic [2:0] {
    ST_IDLE,       // waiting for rx byte or frame
    ST_RX_ADDR,    // register read, waiting for address
    ST_TX_DECODE,  // header -> byte count or drop
    ST_TX_LOAD,    // strobe next byte into transmitter
    ST_TX_WAIT     // wait for transmitter done
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_link_top.sv
// ====================
// uart link top, controller with serial tx and rx
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_link_top import uart_link_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 217  // 25 MHz / 115200 baud
) (
  input  logic     i_CLK,
  input  logic     i_RST,
  // serial lines
  input  logic     i_UART_RXD,
  output logic     o_UART_TXD,
  // core interface
  input  frame_t   i_UART_DATA_TX,
  input  logic     i_UART_DATA_TX_VALID,
  output logic     o_UART_DATA_TX_READY,
  output rx_word_t o_UART_DATA_RX,
  output logic     o_UART_DATA_RX_VALID,
  input  logic     i_CORE_BUSY
);

  logic  w_rx_valid;
  byte_t w_rx_byte;
  logic  w_tx_start;
  byte_t w_tx_byte;
  logic  w_tx_done;

  uart_controller u_ctrl (
    .i_CLK                (i_CLK),
    .i_RST                (i_RST),
    .i_UART_DATA_TX       (i_UART_DATA_TX),
    .i_UART_DATA_TX_VALID (i_UART_DATA_TX_VALID),
    .o_UART_DATA_TX_READY (o_UART_DATA_TX_READY),
    .o_UART_DATA_RX       (o_UART_DATA_RX),
    .o_UART_DATA_RX_VALID (o_UART_DATA_RX_VALID),
    .i_CORE_BUSY          (i_CORE_BUSY),
    .i_RX_VALID           (w_rx_valid),
    .i_RX_BYTE            (w_rx_byte),
    .o_TX_START           (w_tx_start),
    .o_TX_BYTE            (w_tx_byte),
    .i_TX_DONE            (w_tx_done)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .i_CLK   (i_CLK),
    .i_RST   (i_RST),
    .i_START (w_tx_start),
    .i_BYTE  (w_tx_byte),
    .o_TXD   (o_UART_TXD),
    .o_DONE  (w_tx_done)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .i_CLK   (i_CLK),
    .i_RST   (i_RST),
    .i_RXD   (i_UART_RXD),
    .o_VALID (w_rx_valid),
    .o_BYTE  (w_rx_byte)
  );

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// ====================
// uart receiver, mid-bit sampling of 8N1 characters
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_link_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 217  // clock cycles per serial bit
) (
  input  logic  i_CLK,
  input  logic  i_RST,
  input  logic  i_RXD,    // async serial in
  output logic  o_VALID,  // one pulse per character, mid stop bit
  output byte_t o_BYTE
);

  localparam int unsigned      CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_CLK = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,  // half bit to start-bit centre
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        r_state;
  logic [1:0]       r_sync;     // two-flop synchronizer
  logic             r_rxd_d;    // previous synced level
  logic [CNT_W-1:0] r_clk_cnt;
  logic [2:0]       r_bit_idx;
  byte_t            r_shift;    // lsb first
  logic             w_rxd;
  logic             w_fall;
  logic             w_half;
  logic             w_full;

  assign w_rxd  = r_sync[1];
  assign w_fall = r_rxd_d && !w_rxd;  // start edge
  assign w_half = (r_clk_cnt == HALF_CLK);
  assign w_full = (r_clk_cnt == LAST_CLK);
  assign o_BYTE = r_shift;

  // ==================== control
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state   <= RX_IDLE;
      r_sync    <= 2'b11;
      r_rxd_d   <= 1'b1;
      r_clk_cnt <= '0;
      r_bit_idx <= '0;
      o_VALID   <= 1'b0;
    end else begin
      r_sync  <= {r_sync[0], i_RXD};
      r_rxd_d <= w_rxd;
      o_VALID <= 1'b0;
      case (r_state)
        RX_IDLE: begin
          r_clk_cnt <= '0;
          if (w_fall) r_state <= RX_START;
        end
        RX_START: begin
          if (w_half) begin
            r_clk_cnt <= '0;
            r_bit_idx <= '0;
            r_state   <= w_rxd ? RX_IDLE : RX_DATA;  // high again = glitch
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (w_full) begin
            r_clk_cnt <= '0;
            r_bit_idx <= r_bit_idx + 3'd1;
            if (r_bit_idx == 3'd7) r_state <= RX_STOP;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (w_full) begin
            o_VALID <= 1'b1;  // stop level not checked
            r_state <= RX_IDLE;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        default: r_state <= RX_IDLE;
      endcase
    end
  end

  // ==================== data bits
  always_ff @(posedge i_CLK) begin
    if ((r_state == RX_DATA) && w_full) begin
      r_shift <= {w_rxd, r_shift[7:1]};  // sample at bit centre
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// ====================
// uart transmitter, one 8N1 character per start strobe
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_link_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 217  // clock cycles per serial bit
) (
  input  logic  i_CLK,
  input  logic  i_RST,
  input  logic  i_START,  // one-cycle strobe, ignored while busy
  input  byte_t i_BYTE,
  output logic  o_TXD,    // serial out, idles high
  output logic  o_DONE    // last cycle of stop bit
);

  localparam int unsigned      CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0]       LAST_BIT = 4'd9;  // start + 8 data + stop

  logic             r_busy;
  logic [CNT_W-1:0] r_clk_cnt;  // baud counter
  logic [3:0]       r_bit_idx;  // 0 start .. 9 stop
  logic [9:0]       r_shift;    // {stop, data, start}, lsb on the line
  logic             w_bit_end;

  assign w_bit_end = r_busy && (r_clk_cnt == LAST_CLK);
  assign o_DONE    = w_bit_end && (r_bit_idx == LAST_BIT);
  assign o_TXD     = r_shift[0];  // all ones when idle

  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_busy    <= 1'b0;
      r_clk_cnt <= '0;
      r_bit_idx <= '0;
      r_shift   <= '1;  // line high out of reset
    end else if (!r_busy) begin
      if (i_START) begin
        r_busy    <= 1'b1;
        r_clk_cnt <= '0;
        r_bit_idx <= '0;
        r_shift   <= {1'b1, i_BYTE, 1'b0};  // start bit goes out next cycle
      end
    end else if (w_bit_end) begin
      r_clk_cnt <= '0;
      r_shift   <= {1'b1, r_shift[9:1]};  // fill with idle level
      if (r_bit_idx == LAST_BIT) begin
        r_busy <= 1'b0;  // stop bit finished
      end else begin
        r_bit_idx <= r_bit_idx + 4'd1;
      end
    end else begin
      r_clk_cnt <= r_clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tb/uart_link_checker.sv
// ====================
// uart link port assertions, bound into the top level
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_link_checker (
  input logic i_CLK,
  input logic i_RST,
  input logic i_TXD,
  input logic i_TX_READY,
  input logic i_TX_VALID,
  input logic i_RX_VALID
);

  int fail_cnt = 0;  // failed assertion count

  // command word strobe lasts one cycle
  a_rx_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
    i_RX_VALID |=> !i_RX_VALID)
    else begin
      fail_cnt++;
      $error("command word strobe high for two cycles");
    end

  // frame taken, ready drops next cycle
  a_ready_drop: assert property (@(posedge i_CLK) disable iff (i_RST)
    (i_TX_READY && i_TX_VALID) |=> !i_TX_READY)
    else begin
      fail_cnt++;
      $error("frame ready stayed high after handshake");
    end

  // line idle whenever a new frame can be taken
  a_line_idle: assert property (@(posedge i_CLK) disable iff (i_RST)
    i_TX_READY |-> i_TXD)
    else begin
      fail_cnt++;
      $error("serial output low while frame ready is high");
    end

endmodule

bind uart_link_top uart_link_checker u_checker (
  .i_CLK      (i_CLK),
  .i_RST      (i_RST),
  .i_TXD      (o_UART_TXD),
  .i_TX_READY (o_UART_DATA_TX_READY),
  .i_TX_VALID (i_UART_DATA_TX_VALID),
  .i_RX_VALID (o_UART_DATA_RX_VALID)
);

`default_nettype wire

// File: tb/uart_link_tb.sv
// ====================
// uart link testbench, lfsr stimulus checked against a command and frame model
// ====================
`timescale 1ns/1ps
`default_nettype none

module uart_link_tb import uart_link_pkg::*; ();

  localparam int unsigned CLKS_PER_BIT = 16;  // fast baud for simulation
  localparam int          DRIVE_DLY    = 1;   // ns after rising edge

  logic     i_CLK;
  logic     i_RST;
  logic     i_UART_RXD;
  logic     o_UART_TXD;
  frame_t   i_UART_DATA_TX;
  logic     i_UART_DATA_TX_VALID;
  logic     o_UART_DATA_TX_READY;
  rx_word_t o_UART_DATA_RX;
  logic     o_UART_DATA_RX_VALID;
  logic     i_CORE_BUSY;

  logic [31:0] lfsr;
  byte_t       model_low;  // low byte held by the link
  rx_word_t    got_rx[$];  // words seen on the core side
  byte_t       got_tx[$];  // bytes rebuilt from the serial output

  uart_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (.*);

  initial begin
    i_CLK = 1'b0;
    forever #4 i_CLK = ~i_CLK;  // 8 ns
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic frame_t random_frame(input byte_t hdr);
    return {hdr, 48'(random_bits(48))};  // payload below header
  endfunction

  // ==================== checks
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rx_word(input string name, input rx_word_t got, input rx_word_t exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_tx_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_reset_outputs();
    check_level("o_UART_DATA_RX_VALID", o_UART_DATA_RX_VALID, 1'b0);
    check_rx_word("o_UART_DATA_RX", o_UART_DATA_RX, '0);
    check_level("o_UART_TXD", o_UART_TXD, 1'b1);  // line idles high
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (o_UART_DATA_TX_READY !== 1'b1) begin
      @(negedge i_CLK);
      n++;
      if (n > limit) fail_run("timeout waiting for o_UART_DATA_TX_READY to rise");
    end
  endtask

  // ==================== serial side
  task automatic drive_bit(input logic b);
    @(posedge i_CLK);
    #DRIVE_DLY i_UART_RXD = b;
    repeat (CLKS_PER_BIT - 1) @(posedge i_CLK);  // hold for one bit time
  endtask

  task automatic send_serial(input byte_t b);
    int k;
    drive_bit(1'b0);  // start
    for (k = 0; k < 8; k++) drive_bit(b[k]);  // lsb first
    drive_bit(1'b1);  // stop
  endtask

  // rebuild characters from o_UART_TXD, sampled mid bit
  initial begin : tx_decoder
    byte_t b;
    int    k;
    forever begin
      @(negedge i_CLK);
      if (!i_RST && o_UART_TXD === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge i_CLK);  // start bit centre
        for (k = 0; k < 8; k++) begin
          repeat (CLKS_PER_BIT) @(negedge i_CLK);
          b[k] = o_UART_TXD;
        end
        repeat (CLKS_PER_BIT) @(negedge i_CLK);
        if (o_UART_TXD !== 1'b1) fail_run("stop bit low on o_UART_TXD");
        got_tx.push_back(b);
      end
    end
  end

  always @(negedge i_CLK) begin
    if (!i_RST && o_UART_DATA_RX_VALID) got_rx.push_back(o_UART_DATA_RX);
  end

  task automatic set_busy(input logic b);
    @(posedge i_CLK);
    #DRIVE_DLY i_CORE_BUSY = b;
  endtask

  // ==================== model and items
  // busy core takes stop only; idle core takes run, and reg reads with an address
  task automatic run_inbound(input byte_t cmd, input byte_t addr);
    logic     hit;
    rx_word_t exp;
    int       n;
    hit = 1'b0;
    exp = {cmd, model_low};  // low byte unchanged by default
    n   = 0;
    send_serial(cmd);
    if (i_CORE_BUSY) begin
      hit = (cmd == CMD_STOP);
    end else if (cmd == CMD_RUN) begin
      hit = 1'b1;
    end else if (cmd == CMD_ADS_READ_REG || cmd == CMD_MPR_READ_REG) begin
      send_serial(addr);
      exp       = {cmd, addr};
      model_low = addr;
      hit       = 1'b1;
    end
    if (hit) begin
      while (got_rx.size() == 0) begin
        @(negedge i_CLK);
        n++;
        if (n > 4 * CLKS_PER_BIT) fail_run("timeout waiting for a command word strobe");
      end
      check_rx_word("o_UART_DATA_RX", got_rx.pop_front(), exp);
    end
    repeat (24) @(negedge i_CLK);  // quiet window
    if (got_rx.size() != 0) fail_run("command word strobe that no command called for");
  endtask

  // 0xAA sends 7 bytes, reg read echo sends 3, anything else dropped
  task automatic run_outbound(input frame_t f);
    int n_bytes;
    int k;
    int n;
    n_bytes = 0;
    n       = 0;
    if (f[55:48] == HDR_ADS_DATA) n_bytes = FRAME_BYTES_LONG;
    else if (f[55:48] == CMD_ADS_READ_REG || f[55:48] == CMD_MPR_READ_REG)
      n_bytes = FRAME_BYTES_SHORT;
    wait_ready(2000);
    @(posedge i_CLK);
    #DRIVE_DLY;
    i_UART_DATA_TX       = f;
    i_UART_DATA_TX_VALID = 1'b1;
    @(posedge i_CLK);  // handshake edge, ready was high
    #DRIVE_DLY i_UART_DATA_TX_VALID = 1'b0;
    check_level("o_UART_DATA_TX_READY", o_UART_DATA_TX_READY, 1'b0);
    wait_ready(2000);  // frame sent or dropped
    while (got_tx.size() < n_bytes) begin
      @(negedge i_CLK);
      n++;
      if (n > 4 * CLKS_PER_BIT) fail_run("timeout waiting for bytes on o_UART_TXD");
    end
    for (k = 0; k < n_bytes; k++)
      check_tx_byte("o_UART_TXD", got_tx.pop_front(), f[55 - 8*k -: 8]);  // top byte first
    repeat (4) @(negedge i_CLK);
    if (got_tx.size() != 0) fail_run("extra bytes on o_UART_TXD after a frame");
  endtask

  // ==================== sequence
  initial begin : main_seq
    byte_t cmd;
    int    k;
    lfsr                 = 32'h5879;
    model_low            = 8'h00;  // word cleared by reset
    i_RST                = 1'b1;
    i_UART_RXD           = 1'b1;
    i_UART_DATA_TX       = '0;
    i_UART_DATA_TX_VALID = 1'b0;
    i_CORE_BUSY          = 1'b0;

    repeat (16) begin
      @(negedge i_CLK);
      check_reset_outputs();
    end
    @(posedge i_CLK);
    #DRIVE_DLY i_RST = 1'b0;
    @(negedge i_CLK);
    check_reset_outputs();
    wait_ready(20);

    // idle core
    run_inbound(CMD_RUN, 8'h00);
    run_inbound(CMD_ADS_READ_REG, byte_t'(random_bits(8)));
    run_inbound(CMD_MPR_READ_REG, byte_t'(random_bits(8)));
    run_inbound(CMD_RUN, 8'h00);  // keeps last address
    run_inbound(CMD_STOP, 8'h00);
    for (k = 0; k < 4; k++) begin
      cmd = byte_t'(random_bits(8));
      if (cmd inside {CMD_RUN, CMD_STOP, CMD_ADS_READ_REG, CMD_MPR_READ_REG}) cmd = cmd ^ 8'h80;
      run_inbound(cmd, 8'h00);
    end

    // busy core, stop right after a read shows no address wait
    set_busy(1'b1);
    run_inbound(CMD_RUN, 8'h00);
    run_inbound(CMD_ADS_READ_REG, 8'h00);
    run_inbound(CMD_STOP, 8'h00);
    run_inbound(CMD_MPR_READ_REG, 8'h00);
    run_inbound(CMD_STOP, 8'h00);
    set_busy(1'b0);

    // outbound frames
    for (k = 0; k < 3; k++) run_outbound(random_frame(HDR_ADS_DATA));
    run_outbound(random_frame(CMD_ADS_READ_REG));
    run_outbound(random_frame(CMD_MPR_READ_REG));
    run_outbound(random_frame(HDR_MPR_DATA));  // reserved, dropped
    cmd = byte_t'(random_bits(8));
    if (cmd inside {HDR_ADS_DATA, CMD_ADS_READ_REG, CMD_MPR_READ_REG}) cmd = cmd ^ 8'h01;
    run_outbound(random_frame(cmd));

    // mixed traffic
    for (k = 0; k < 60; k++) begin
      repeat (random_bits(4)) @(posedge i_CLK);  // gap
      set_busy(1'(random_bits(1)));
      if (random_bits(1) != 0) begin
        case (random_bits(3))
          0: cmd = CMD_RUN;
          1: cmd = CMD_STOP;
          2: cmd = CMD_ADS_READ_REG;
          3: cmd = CMD_MPR_READ_REG;
          default: cmd = byte_t'(random_bits(8));
        endcase
        run_inbound(cmd, byte_t'(random_bits(8)));
      end else begin
        case (random_bits(2))
          0: cmd = HDR_ADS_DATA;
          1: cmd = CMD_ADS_READ_REG;
          2: cmd = CMD_MPR_READ_REG;
          default: cmd = byte_t'(random_bits(8));
        endcase
        run_outbound(random_frame(cmd));
      end
    end

    if (dut.u_checker.fail_cnt != 0) begin
      fail_run("bound checker saw assertion failures");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: uart_link.f
rtl/uart_link_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_controller.sv
rtl/uart_link_top.sv
tb/uart_link_checker.sv
tb/uart_link_tb.sv
